// File: pe_pkg.sv
package pe_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////////////
    localparam int DATA_WIDTH      = 16;           // q1.15 per part
    localparam int REG_NUM         = 32;           // registers per element
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int PROG_DEPTH      = 32;           // instruction slots
    localparam int PROG_ADDR_WIDTH = 5;
    localparam int NUM_PE          = 2;
    localparam int ALU_LAT         = 3;
    localparam int PE_LAT          = ALU_LAT + 1;  // read cycle + alu stages

    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;
        logic signed [DATA_WIDTH-1:0] im;
    } cplx_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_CMUL = 3'd3,  // a * conj(b)
        OP_PASS = 3'd4
    } opcode_e;

    typedef struct packed {
        opcode_e                   op;
        logic [REG_ADDR_WIDTH-1:0] src_a;
        logic [REG_ADDR_WIDTH-1:0] src_b;
        logic [REG_ADDR_WIDTH-1:0] dst;
        logic                      wb;     // write result to dst
    } inst_t;

    typedef logic signed [2*DATA_WIDTH-1:0] prod_t;  // one partial product, q2.30
    typedef logic signed [2*DATA_WIDTH:0]   acc_t;   // sum of two products

    //////////////////////////////////////////////////////////////////////////////
    // arithmetic, shared by the alu and the model
    //////////////////////////////////////////////////////////////////////////////
    function automatic prod_t mul_part(input logic signed [DATA_WIDTH-1:0] x,
                                       input logic signed [DATA_WIDTH-1:0] y);
        return x * y;
    endfunction

    // back to q1.15, low bits dropped
    function automatic logic [DATA_WIDTH-1:0] mul_scale(input acc_t p);
        acc_t s;
        s = p >>> (DATA_WIDTH - 1);
        return s[DATA_WIDTH-1:0];
    endfunction

    function automatic cplx_t cplx_add(input cplx_t a, input cplx_t b);
        cplx_t r;
        r.re = a.re + b.re;  // wraps
        r.im = a.im + b.im;
        return r;
    endfunction

    function automatic cplx_t cplx_sub(input cplx_t a, input cplx_t b);
        cplx_t r;
        r.re = a.re - b.re;
        r.im = a.im - b.im;
        return r;
    endfunction

    function automatic cplx_t cplx_mul(input cplx_t a, input cplx_t b);
        acc_t  re;
        acc_t  im;
        cplx_t r;
        re   = mul_part(a.re, b.re) - mul_part(a.im, b.im);
        im   = mul_part(a.re, b.im) + mul_part(a.im, b.re);
        r.re = mul_scale(re);
        r.im = mul_scale(im);
        return r;
    endfunction

    function automatic cplx_t cplx_cmul(input cplx_t a, input cplx_t b);
        acc_t  re;
        acc_t  im;
        cplx_t r;
        re   = mul_part(a.re, b.re) + mul_part(a.im, b.im);
        im   = mul_part(a.im, b.re) - mul_part(a.re, b.im);
        r.re = mul_scale(re);
        r.im = mul_scale(im);
        return r;
    endfunction

    // whole operation in one call; spare codes behave as pass
    function automatic cplx_t cplx_op(input opcode_e op, input cplx_t a, input cplx_t b);
        case (op)
            OP_ADD:  return cplx_add(a, b);
            OP_SUB:  return cplx_sub(a, b);
            OP_MUL:  return cplx_mul(a, b);
            OP_CMUL: return cplx_cmul(a, b);
            default: return a;
        endcase
    endfunction

endpackage

// File: pe_issue_if.sv
`timescale 1ns/1ps

interface pe_issue_if;
    import pe_pkg::*;

    logic                      valid;  // one issued instruction per high cycle
    opcode_e                   op;
    logic [REG_ADDR_WIDTH-1:0] src_a;
    logic [REG_ADDR_WIDTH-1:0] src_b;
    logic [REG_ADDR_WIDTH-1:0] dst;
    logic                      wb;

    // decoder side
    modport ctrl (output valid, op, src_a, src_b, dst, wb);

    modport mem (input valid, src_a, src_b);  // register reads
    modport alu (input valid, op, dst, wb);   // tags ride along the pipe

endinterface

// File: inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               inst_in_v,
    input  pe_pkg::inst_t                      inst_in,
    input  logic [pe_pkg::PROG_ADDR_WIDTH-1:0] rd_addr,
    output pe_pkg::inst_t                      rd_inst,
    output logic [pe_pkg::PROG_ADDR_WIDTH:0]   prog_len
);
    import pe_pkg::*;

    inst_t mem [PROG_DEPTH];  // program slots
    logic  wr_en;

    assign wr_en = inst_in_v && (prog_len < PROG_DEPTH);  // extra words dropped

    // prog_len is also the write pointer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_len <= '0;
        end else if (wr_en) begin
            prog_len <= prog_len + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[prog_len[PROG_ADDR_WIDTH-1:0]] <= inst_in;
        end
    end

    assign rd_inst = mem[rd_addr];  // comb read at pc

endmodule

// File: pe_control.sv
`timescale 1ns/1ps

module pe_control (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic [pe_pkg::PROG_ADDR_WIDTH:0]   prog_len,
    input  pe_pkg::inst_t                      rd_inst,
    output logic [pe_pkg::PROG_ADDR_WIDTH-1:0] rd_addr,
    output logic                               busy,
    pe_issue_if.ctrl                           issue
);
    import pe_pkg::*;

    localparam int DRAIN_W = $clog2(PE_LAT + 1);

    logic                       running;  // issuing
    logic [PROG_ADDR_WIDTH-1:0] pc;
    logic [DRAIN_W-1:0]         drain;    // results still in flight
    logic                       go;
    logic                       last;     // final instruction this cycle

    assign busy    = running || (drain != '0);
    assign go      = start && !busy && (prog_len != '0);  // start while busy is dropped
    assign last    = (({1'b0, pc} + 1'b1) == prog_len);
    assign rd_addr = pc;

    //////////////////////////////////////////////////////////////////////////////
    // run sequencing
    //////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            pc      <= '0;
            drain   <= '0;
        end else begin
            if (drain != '0) begin
                drain <= drain - 1'b1;
            end
            if (go) begin
                running <= 1'b1;
                pc      <= '0;
            end else if (running) begin
                pc <= pc + 1'b1;
                if (last) begin
                    running <= 1'b0;
                    drain   <= DRAIN_W'(PE_LAT);  // busy until last result out
                end
            end
        end
    end

    // decode
    always_comb begin
        issue.valid = running;
        issue.src_a = rd_inst.src_a;
        issue.src_b = rd_inst.src_b;
        issue.dst   = rd_inst.dst;
        issue.wb    = rd_inst.wb;
        case (rd_inst.op)
            OP_ADD, OP_SUB, OP_MUL, OP_CMUL: issue.op = rd_inst.op;
            default:                         issue.op = OP_PASS;  // spare codes
        endcase
    end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              ld_v,
    input  logic [pe_pkg::REG_ADDR_WIDTH-1:0] ld_addr,
    input  pe_pkg::cplx_t                     ld_data,
    pe_issue_if.mem                           issue,
    input  logic                              wb_v,
    input  logic [pe_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    input  pe_pkg::cplx_t                     wb_data,
    output pe_pkg::cplx_t                     rdata_a,
    output pe_pkg::cplx_t                     rdata_b
);
    import pe_pkg::*;

    cplx_t regs [REG_NUM];

    // one write port, load first
    logic                      wr_en;
    logic [REG_ADDR_WIDTH-1:0] wr_addr;
    cplx_t                     wr_data;

    assign wr_en   = ld_v || wb_v;
    assign wr_addr = ld_v ? ld_addr : wb_addr;
    assign wr_data = ld_v ? ld_data : wb_data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // sampled at the issue edge
    // a write on that same edge is seen, anything later is not
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else if (issue.valid) begin
            rdata_a <= (wr_en && wr_addr == issue.src_a) ? wr_data : regs[issue.src_a];
            rdata_b <= (wr_en && wr_addr == issue.src_b) ? wr_data : regs[issue.src_b];
        end
    end

endmodule

// File: complex_alu.sv
`timescale 1ns/1ps

module complex_alu (
    input  logic                              clk,
    input  logic                              arst_n,
    pe_issue_if.alu                           issue,
    input  pe_pkg::cplx_t                     rdata_a,
    input  pe_pkg::cplx_t                     rdata_b,
    output logic                              res_v,
    output pe_pkg::cplx_t                     res,
    output logic [pe_pkg::REG_ADDR_WIDTH-1:0] res_dst,
    output logic                              res_wb
);
    import pe_pkg::*;

    // what travels beside the data
    typedef struct packed {
        logic                      v;
        opcode_e                   op;
        logic [REG_ADDR_WIDTH-1:0] dst;
        logic                      wb;
    } tag_t;

    tag_t  tag0;    // lines up with rdata
    tag_t  tag1;
    tag_t  tag2;
    prod_t p_rr;    // re*re
    prod_t p_ii;    // im*im
    prod_t p_ri;    // a.re*b.im
    prod_t p_ir;    // a.im*b.re
    cplx_t sum1;    // add / sub / pass path
    cplx_t sum2;
    acc_t  acc_re;
    acc_t  acc_im;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag0    <= '0;
            tag1    <= '0;
            tag2    <= '0;
            res_v   <= 1'b0;
            res_dst <= '0;
            res_wb  <= 1'b0;
        end else begin
            tag0    <= '{issue.valid, issue.op, issue.dst, issue.wb};
            tag1    <= tag0;
            tag2    <= tag1;
            res_v   <= tag2.v;
            res_dst <= tag2.dst;
            res_wb  <= tag2.wb;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // datapath, three stages
    //////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        p_rr <= mul_part(rdata_a.re, rdata_b.re);
        p_ii <= mul_part(rdata_a.im, rdata_b.im);
        p_ri <= mul_part(rdata_a.re, rdata_b.im);
        p_ir <= mul_part(rdata_a.im, rdata_b.re);
        case (tag0.op)
            OP_ADD:  sum1 <= cplx_add(rdata_a, rdata_b);
            OP_SUB:  sum1 <= cplx_sub(rdata_a, rdata_b);
            default: sum1 <= rdata_a;
        endcase
    end

    always_ff @(posedge clk) begin
        sum2 <= sum1;
        if (tag1.op == OP_CMUL) begin  // conj(b) flips the im products
            acc_re <= p_rr + p_ii;
            acc_im <= p_ir - p_ri;
        end else begin
            acc_re <= p_rr - p_ii;
            acc_im <= p_ri + p_ir;
        end
    end

    always_ff @(posedge clk) begin
        if (tag2.op == OP_MUL || tag2.op == OP_CMUL) begin
            res.re <= mul_scale(acc_re);  // >>> 15, truncate
            res.im <= mul_scale(acc_im);
        end else begin
            res <= sum2;
        end
    end

endmodule

// File: pe.sv
`timescale 1ns/1ps

module pe (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          din_v,
    input  pe_pkg::cplx_t din,
    input  logic          inst_in_v,
    input  pe_pkg::inst_t inst_in,
    input  logic          start,
    output logic          dout_v,
    output pe_pkg::cplx_t dout,
    output logic          fwd_v,
    output pe_pkg::cplx_t fwd,
    output logic          busy
);
    import pe_pkg::*;

    logic [REG_ADDR_WIDTH:0]    ld_cnt;    // words kept, stops at REG_NUM
    logic                       ld_full;
    logic                       ld_v;
    logic                       wb_v;      // result goes back to regs
    logic [PROG_ADDR_WIDTH-1:0] pc;
    inst_t                      cur_inst;
    logic [PROG_ADDR_WIDTH:0]   prog_len;
    cplx_t                      rdata_a;
    cplx_t                      rdata_b;
    logic [REG_ADDR_WIDTH-1:0]  res_dst;
    logic                       res_wb;

    pe_issue_if issue ();

    //////////////////////////////////////////////////////////////////////////////
    // load fill and forward
    //////////////////////////////////////////////////////////////////////////////
    assign ld_full = (ld_cnt == REG_NUM);
    assign ld_v    = din_v && !ld_full;
    assign wb_v    = dout_v && res_wb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_cnt <= '0;
            fwd_v  <= 1'b0;
        end else begin
            fwd_v <= din_v && ld_full;  // overflow goes downstream
            if (ld_v) begin
                ld_cnt <= ld_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_v && ld_full) begin
            fwd <= din;
        end
    end

    inst_mem u_imem (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .rd_addr   (pc),
        .rd_inst   (cur_inst),
        .prog_len  (prog_len)
    );

    pe_control u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .prog_len (prog_len),
        .rd_inst  (cur_inst),
        .rd_addr  (pc),
        .busy     (busy),
        .issue    (issue.ctrl)
    );

    data_mem u_dmem (
        .clk     (clk),
        .arst_n  (arst_n),
        .ld_v    (ld_v),
        .ld_addr (ld_cnt[REG_ADDR_WIDTH-1:0]),  // arrival order
        .ld_data (din),
        .issue   (issue.mem),
        .wb_v    (wb_v),
        .wb_addr (res_dst),
        .wb_data (dout),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    complex_alu u_alu (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue.alu),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .res_v   (dout_v),     // result leaves directly
        .res     (dout),
        .res_dst (res_dst),
        .res_wb  (res_wb)
    );

endmodule

// File: pe_array.sv
`timescale 1ns/1ps

module pe_array (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               inst_in_v,
    input  pe_pkg::inst_t                      inst_in,
    input  logic                               din_v,
    input  pe_pkg::cplx_t                      din,
    input  logic                               start,
    output logic                               busy,
    output logic [pe_pkg::NUM_PE-1:0]          dout_v,
    output pe_pkg::cplx_t [pe_pkg::NUM_PE-1:0] dout,
    output logic                               spill_v,
    output pe_pkg::cplx_t                      spill
);
    import pe_pkg::*;

    logic [NUM_PE:0]   chain_v;  // [i] feeds element i, top entry spills
    cplx_t [NUM_PE:0]  chain_d;
    logic [NUM_PE-1:0] pe_busy;

    assign chain_v[0] = din_v;
    assign chain_d[0] = din;

    // program and start go to every element
    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        pe u_pe (
            .clk       (clk),
            .arst_n    (arst_n),
            .din_v     (chain_v[i]),
            .din       (chain_d[i]),
            .inst_in_v (inst_in_v),
            .inst_in   (inst_in),
            .start     (start),
            .dout_v    (dout_v[i]),
            .dout      (dout[i]),
            .fwd_v     (chain_v[i+1]),
            .fwd       (chain_d[i+1]),
            .busy      (pe_busy[i])
        );
    end

    assign spill_v = chain_v[NUM_PE];
    assign spill   = chain_d[NUM_PE];
    assign busy    = pe_busy[0];  // lockstep

endmodule

// File: pe_assertions.sv
`timescale 1ns/1ps

module pe_assertions (
    input logic clk,
    input logic arst_n,
    input logic dout_v,
    input logic fwd_v,
    input logic busy,
    input logic ld_v,
    input logic wb_v
);
    import pe_pkg::*;

    int unsigned idle_cnt;      // cycles since busy was last high
    int          fail_cnt = 0;  // read by the testbench

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idle_cnt <= PE_LAT + 1;
        end else if (busy) begin
            idle_cnt <= 0;
        end else if (idle_cnt <= PE_LAT) begin
            idle_cnt <= idle_cnt + 1;  // saturates past PE_LAT
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !dout_v && !fwd_v)
        else begin
            fail_cnt++;
            $error("result or forward strobe right after reset release");
        end

    // results trail busy by at most PE_LAT
    a_dout_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        dout_v |-> (busy || idle_cnt < PE_LAT))
        else begin
            fail_cnt++;
            $error("result strobe outside a run");
        end

    a_no_ld_wb: assert property (@(posedge clk) disable iff (!arst_n) !(ld_v && wb_v))
        else begin
            fail_cnt++;
            $error("load and write-back on the same cycle");
        end

endmodule

// File: pe_checker.sv
`timescale 1ns/1ps

module pe_checker (
    input logic                               clk,
    input logic                               arst_n,
    input logic                               inst_in_v,
    input pe_pkg::inst_t                      inst_in,
    input logic                               din_v,
    input pe_pkg::cplx_t                      din,
    input logic                               start,
    input logic                               busy,
    input logic [pe_pkg::NUM_PE-1:0]          dout_v,
    input pe_pkg::cplx_t [pe_pkg::NUM_PE-1:0] dout,
    input logic                               spill_v,
    input pe_pkg::cplx_t                      spill
);
    import pe_pkg::*;

    string test_name  = "none";
    int    err_value  = 0;
    int    err_strobe = 0;

    cplx_t regs    [NUM_PE][REG_NUM];     // model register files
    cplx_t exp_mem [NUM_PE][PROG_DEPTH];  // expected results of the run
    int    exp_rd  [NUM_PE];
    int    ld_cnt  [NUM_PE];
    int    exp_len;
    inst_t prog    [PROG_DEPTH];
    int    prog_len;
    int    busy_left;                     // model busy, in cycles
    bit    run_open;
    cplx_t spill_q [$];

    // q1.15 arithmetic, products kept wide then >>> 15 and truncated
    function automatic cplx_t model_op(input opcode_e op, input cplx_t a, input cplx_t b);
        longint ar, ai, br, bi, re, im;
        cplx_t  r;
        ar = $signed(a.re);
        ai = $signed(a.im);
        br = $signed(b.re);
        bi = $signed(b.im);
        case (op)
            OP_ADD: begin
                re = ar + br;
                im = ai + bi;
            end
            OP_SUB: begin
                re = ar - br;
                im = ai - bi;
            end
            OP_MUL: begin
                re = (ar * br - ai * bi) >>> 15;
                im = (ar * bi + ai * br) >>> 15;
            end
            OP_CMUL: begin  // b conjugated
                re = (ar * br + ai * bi) >>> 15;
                im = (ai * br - ar * bi) >>> 15;
            end
            default: begin
                re = ar;
                im = ai;
            end
        endcase
        r.re = re[DATA_WIDTH-1:0];
        r.im = im[DATA_WIDTH-1:0];
        return r;
    endfunction

    task automatic reset_model();
        for (int p = 0; p < NUM_PE; p++) begin
            ld_cnt[p] = 0;
            exp_rd[p] = 0;
        end
        exp_len   = 0;
        prog_len  = 0;
        busy_left = 0;
        run_open  = 0;
        spill_q.delete();
    endtask

    // first free element takes the word, past the last one it spills
    task automatic load_word(input cplx_t w);
        bit placed;
        placed = 0;
        for (int p = 0; p < NUM_PE; p++) begin
            if (!placed && ld_cnt[p] < REG_NUM) begin
                regs[p][ld_cnt[p]] = w;
                ld_cnt[p]++;
                placed = 1;
            end
        end
        if (!placed) begin
            spill_q.push_back(w);
        end
    endtask

    // whole run up front; a write-back is seen PE_LAT slots later
    task automatic launch_run();
        cplx_t a;
        cplx_t b;
        int    first;
        first = (prog_len > PE_LAT) ? prog_len - PE_LAT : 0;
        for (int p = 0; p < NUM_PE; p++) begin
            for (int k = 0; k < prog_len; k++) begin
                if (k >= PE_LAT && prog[k-PE_LAT].wb) begin
                    regs[p][prog[k-PE_LAT].dst] = exp_mem[p][k-PE_LAT];
                end
                a = regs[p][prog[k].src_a];
                b = regs[p][prog[k].src_b];
                exp_mem[p][k] = model_op(prog[k].op, a, b);
            end
            for (int k = first; k < prog_len; k++) begin  // tail write-backs
                if (prog[k].wb) begin
                    regs[p][prog[k].dst] = exp_mem[p][k];
                end
            end
            exp_rd[p] = 0;
        end
        exp_len   = prog_len;
        busy_left = prog_len + PE_LAT;
        run_open  = 1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output compare
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_outputs();
        if (busy !== (busy_left != 0)) begin
            err_value++;
            $display("[FAIL] %s: busy expected %0b actual %0b",
                     test_name, busy_left != 0, busy);
        end
        for (int p = 0; p < NUM_PE; p++) begin
            if (dout_v[p] !== 1'b0) begin
                if (exp_rd[p] >= exp_len) begin
                    err_strobe++;
                    $display("%s: result strobe on element %0d with nothing expected",
                             test_name, p);
                end else begin
                    if (dout[p] !== exp_mem[p][exp_rd[p]]) begin
                        err_value++;
                        $display("[FAIL] %s: dout[%0d] slot %0d expected %h actual %h",
                                 test_name, p, exp_rd[p], exp_mem[p][exp_rd[p]], dout[p]);
                    end
                    exp_rd[p]++;
                end
            end
        end
        if (spill_v !== 1'b0) begin
            if (spill_q.size() == 0) begin
                err_strobe++;
                $display("%s: spill strobe with no word due", test_name);
            end else if (spill !== spill_q[0]) begin
                err_value++;
                $display("[FAIL] %s: spill expected %h actual %h", test_name, spill_q[0], spill);
                void'(spill_q.pop_front());
            end else begin
                void'(spill_q.pop_front());
            end
        end
        if (run_open && busy_left == 0) begin  // run over, count the results
            for (int p = 0; p < NUM_PE; p++) begin
                if (exp_rd[p] != exp_len) begin
                    err_strobe++;
                    $display("%s: element %0d gave %0d results, %0d expected",
                             test_name, p, exp_rd[p], exp_len);
                end
            end
            run_open = 0;
        end
    endtask

    task automatic check_drained();
        if (spill_q.size() != 0) begin
            err_strobe++;
            $display("%s: %0d spill words never came out", test_name, spill_q.size());
        end
    endtask

    // sampled mid cycle, inputs and outputs both settled
    always @(negedge clk) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            check_outputs();
            if (busy_left != 0) begin
                busy_left--;
            end else if (start && prog_len != 0) begin
                launch_run();
            end
            if (din_v) begin
                load_word(din);
            end
            if (inst_in_v && prog_len < PROG_DEPTH) begin
                prog[prog_len] = inst_in;
                prog_len++;
            end
        end
    end

endmodule

// File: tb_pe_array.sv
`timescale 1ns/1ps

module tb_pe_array;
    import pe_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_SEQ      = 9;  // fresh reset+load sequences in the run
    localparam int WATCHDOG   = N_SEQ * (2 * REG_NUM * NUM_PE + PROG_DEPTH + 64) * CLK_PERIOD;

    logic                     clk;
    logic                     arst_n;
    logic                     inst_in_v;
    inst_t                    inst_in;
    logic                     din_v;
    cplx_t                    din;
    logic                     start;
    logic                     busy;
    logic [NUM_PE-1:0]        dout_v;
    cplx_t [NUM_PE-1:0]       dout;
    logic                     spill_v;
    cplx_t                    spill;
    int                       run_errors = 0;  // runs that never finished
    int                       assert_fail [NUM_PE];

    pe_array uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .din_v     (din_v),
        .din       (din),
        .start     (start),
        .busy      (busy),
        .dout_v    (dout_v),
        .dout      (dout),
        .spill_v   (spill_v),
        .spill     (spill)
    );

    pe_checker chk (.*);

    bind pe pe_assertions u_assert (
        .clk    (clk),
        .arst_n (arst_n),
        .dout_v (dout_v),
        .fwd_v  (fwd_v),
        .busy   (busy),
        .ld_v   (ld_v),
        .wb_v   (wb_v)
    );

    // assertion hits from every element
    for (genvar i = 0; i < NUM_PE; i++) begin : g_af
        assign assert_fail[i] = uut.g_pe[i].u_pe.u_assert.fail_cnt;
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic tick();
        @(posedge clk);
        #2;  // inputs move just after the edge
    endtask

    task automatic apply_reset();
        tick();
        arst_n    = 1'b0;
        din_v     = 1'b0;
        inst_in_v = 1'b0;
        start     = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic load_data(input int n);
        for (int i = 0; i < n; i++) begin
            tick();
            din_v = 1'b1;
            din   = $urandom;
        end
        tick();
        din_v = 1'b0;
        repeat (NUM_PE + 1) tick();  // let the forward chain empty
    endtask

    task automatic fresh_start(input int n);
        apply_reset();
        load_data(n);
    endtask

    // dependent programs read a result 1 to 6 slots back
    task automatic load_program(input int len, input bit dependent);
        inst_t prog [PROG_DEPTH + 8];
        int    d;
        for (int k = 0; k < len; k++) begin
            if (k < 5) begin
                prog[k].op = opcode_e'(k);  // every opcode at least once
            end else if (dependent) begin
                prog[k].op = opcode_e'($urandom_range(4, 0));
            end else begin
                prog[k].op = opcode_e'($urandom_range(7, 0));  // spare codes too
            end
            prog[k].src_a = REG_ADDR_WIDTH'($urandom);
            prog[k].src_b = REG_ADDR_WIDTH'($urandom);
            prog[k].dst   = REG_ADDR_WIDTH'($urandom);
            prog[k].wb    = dependent;
            d = 1 + (k % 6);
            if (dependent && k >= d) begin
                prog[k].src_a = prog[k-d].dst;
            end
        end
        for (int k = 0; k < len; k++) begin
            tick();
            inst_in_v = 1'b1;
            inst_in   = prog[k];
        end
        tick();
        inst_in_v = 1'b0;
    endtask

    task automatic run_program(input bit poke);
        int n;
        tick();
        start = 1'b1;
        tick();
        start = 1'b0;
        n = 0;
        while (busy !== 1'b1 && n < 8) begin
            tick();
            n++;
        end
        if (poke) begin  // extra start mid run
            tick();
            start = 1'b1;
            tick();
            start = 1'b0;
        end
        n = 0;
        while (busy !== 1'b0 && n < PROG_DEPTH + 4 * PE_LAT) begin
            tick();
            n++;
        end
        if (busy !== 1'b0) begin
            run_errors++;
            $display("%s: run did not finish, busy still high", chk.test_name);
        end
        tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int total;
        arst_n     = 1'b0;
        inst_in_v  = 1'b0;
        inst_in    = '0;
        din_v      = 1'b0;
        din        = '0;
        start      = 1'b0;
        void'($urandom(61));

        chk.test_name = "load";
        fresh_start(NUM_PE * REG_NUM + 10);
        chk.check_drained();

        chk.test_name = "arith";
        fresh_start(NUM_PE * REG_NUM);
        load_program(PROG_DEPTH + 2, 1'b0);  // last two words dropped
        run_program(1'b0);
        fresh_start(NUM_PE * REG_NUM);
        load_program(17, 1'b0);
        run_program(1'b0);
        fresh_start(NUM_PE * REG_NUM);
        load_program(5, 1'b0);
        run_program(1'b0);

        chk.test_name = "hazard";
        repeat (2) begin
            fresh_start(NUM_PE * REG_NUM);
            load_program(PROG_DEPTH, 1'b1);
            run_program(1'b0);
        end

        chk.test_name = "rerun";
        fresh_start(NUM_PE * REG_NUM);
        load_program(24, 1'b1);
        run_program(1'b0);
        run_program(1'b1);  // regs carry the first run

        chk.test_name = "reset";
        fresh_start(NUM_PE * REG_NUM);
        load_program(PROG_DEPTH, 1'b1);
        tick();
        start = 1'b1;
        tick();
        start = 1'b0;
        repeat (8) tick();
        apply_reset();  // cut the run short
        repeat (2) tick();
        fresh_start(NUM_PE * REG_NUM);
        load_program(PROG_DEPTH, 1'b1);
        run_program(1'b0);
        repeat (4) tick();

        total = chk.err_value + chk.err_strobe + run_errors;
        for (int i = 0; i < NUM_PE; i++) begin
            total += assert_fail[i];
        end
        $display("errors: value %0d, strobe %0d, run %0d, total %0d",
                 chk.err_value, chk.err_strobe, run_errors, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG);
        $display("watchdog expired after %0d ns, simulation stuck", WATCHDOG);
        $display("test failed");
        $finish;
    end

endmodule

// File: pe_array.f
pe_pkg.sv
pe_issue_if.sv
inst_mem.sv
pe_control.sv
data_mem.sv
complex_alu.sv
pe.sv
pe_array.sv
pe_assertions.sv
pe_checker.sv
tb_pe_array.sv

// File: Bender.yml
package:
  name: pe_array

sources:
  - pe_pkg.sv
  - pe_issue_if.sv
  - inst_mem.sv
  - pe_control.sv
  - data_mem.sv
  - complex_alu.sv
  - pe.sv
  - pe_array.sv
  - target: simulation
    files:
      - pe_assertions.sv
      - pe_checker.sv
      - tb_pe_array.sv
